/* hw/pcxt_pkg.sv */
// PC/XT glue shared definitions

package pcxt_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and constants
	////////////////////////////////////////////////////////////////////////////

	// Core colour depth and widened VGA depth
	localparam int COLOR_BITS = 6;
	localparam int VGA_BITS = 8;

	// Luma weights out of 256 (BT.709)
	localparam int LUMA_R_COEF = 54;
	localparam int LUMA_G_COEF = 183;
	localparam int LUMA_B_COEF = 18;

	// HDMI aspect ratio, 4:3 when the menu leaves it at original
	localparam int ASPECT_ARX_DEFAULT = 4;
	localparam int ASPECT_ARY_DEFAULT = 3;
	localparam int ASPECT_BITS = 13;

	// CPU reset tail after system reset release
	localparam int CPU_RESET_HOLD = 42;
	localparam int SPLASH_SECONDS = 5;

	// BIOS download slot, reloading it restarts the machine
	localparam int BOOT_ROM_INDEX = 0;

	// Mixer headroom and output sample width
	localparam int AUDIO_MIX_BITS = 17;
	localparam int AUDIO_BITS = 16;

	// Hold lengths for real hardware at 50 MHz
	localparam int SYS_RESET_HOLD_DEFAULT = 65535;
	localparam int SPLASH_TICK_DEFAULT = 50000000;
	localparam int LED_HOLD_DEFAULT = 4500000;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MONO_COLOR = 2'd0,
		MONO_GREEN = 2'd1,
		MONO_AMBER = 2'd2,
		MONO_BW = 2'd3
	} mono_mode_e;

	// Value 3 is not offered in the menu
	typedef enum logic [1:0] {
		VOUT_CGA = 2'd0,
		VOUT_TANDY = 2'd1,
		VOUT_MDA = 2'd2
	} video_out_e;

	// Menu status word, MSB first
	typedef struct packed {
		logic [21:0] reserved_hi;
		logic [1:0] aspect;
		logic splash_skip;
		logic [1:0] reserved_lo;
		video_out_e video_out;
		mono_mode_e mono_mode;
		logic menu_reset;
	} core_status_t;

	typedef struct packed {
		logic [COLOR_BITS-1:0] r;
		logic [COLOR_BITS-1:0] g;
		logic [COLOR_BITS-1:0] b;
		logic hsync;
		logic vsync;
		logic de;
	} core_pixel_t;

	typedef struct packed {
		logic [VGA_BITS-1:0] r;
		logic [VGA_BITS-1:0] g;
		logic [VGA_BITS-1:0] b;
		logic hsync;
		logic vsync;
		logic de;
	} vga_pixel_t;

	typedef struct packed {
		logic active;
		logic [7:0] index;
	} download_t;

	// OPL2 is two's complement, Tandy is offset binary
	typedef struct packed {
		logic signed [15:0] opl2;
		logic speaker;
		logic [7:0] tandy;
	} sound_in_t;

endpackage

/* hw/reset_sequencer.sv */
// System and CPU reset sequencer

`timescale 1ns/1ps

module reset_sequencer #(
	parameter int SYS_RESET_HOLD = pcxt_pkg::SYS_RESET_HOLD_DEFAULT
) (
	input logic CLK_50M,
	input logic reset_wire,
	input pcxt_pkg::core_status_t status,
	input logic user_button,
	input pcxt_pkg::download_t download,
	input logic splash_active,
	output logic sys_reset,
	output logic cpu_reset
);

	localparam int SYS_CNT_W = $clog2(SYS_RESET_HOLD + 1);
	localparam int CPU_CNT_W = $clog2(pcxt_pkg::CPU_RESET_HOLD + 1);

	logic request;
	logic boot_reload;
	logic [SYS_CNT_W-1:0] sys_cnt;
	logic [CPU_CNT_W-1:0] cpu_cnt;

	// BIOS reload restarts the core
	assign boot_reload = download.active &&
		(download.index == 8'(pcxt_pkg::BOOT_ROM_INDEX));

	// All reset sources merged
	assign request = reset_wire | status.menu_reset | user_button | boot_reload |
		splash_active;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 system reset stretch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset <= 1'b1;
			sys_cnt <= '0;
		end else if (request) begin
			// Any request restarts the hold
			sys_reset <= 1'b1;
			sys_cnt <= '0;
		end else if (sys_reset) begin
			if (sys_cnt == SYS_CNT_W'(SYS_RESET_HOLD - 1))
				sys_reset <= 1'b0;
			else
				sys_cnt <= sys_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2 CPU reset tail
	////////////////////////////////////////////////////////////////////////////

	// Counts only once system reset is gone
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset <= 1'b1;
			cpu_cnt <= '0;
		end else if (request || sys_reset) begin
			cpu_reset <= 1'b1;
			cpu_cnt <= '0;
		end else if (cpu_reset) begin
			if (cpu_cnt == CPU_CNT_W'(pcxt_pkg::CPU_RESET_HOLD - 1))
				cpu_reset <= 1'b0;
			else
				cpu_cnt <= cpu_cnt + 1'b1;
		end
	end

	// CPU must stay in reset for the whole system reset
	a_cpu_covers_sys: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> cpu_reset)
		else $error("cpu_reset released while sys_reset high");

endmodule

/* hw/splash_timer.sv */
// Splash screen hold timer

`timescale 1ns/1ps

module splash_timer #(
	parameter int SPLASH_TICK = pcxt_pkg::SPLASH_TICK_DEFAULT
) (
	input logic CLK_50M,
	input logic reset_wire,
	input logic splash_skip,
	output logic splash_active
);

	localparam int TICK_W = $clog2(SPLASH_TICK + 1);
	localparam int SEC_W = $clog2(pcxt_pkg::SPLASH_SECONDS + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic [SEC_W-1:0] sec_cnt;
	logic last_tick;

	// End of one second
	assign last_tick = (tick_cnt == TICK_W'(SPLASH_TICK - 1));

	// Counters freeze once the splash is over
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt <= '0;
			sec_cnt <= '0;
		end else if (splash_active) begin
			if (splash_skip) begin
				// Menu turned the splash off
				splash_active <= 1'b0;
			end else if (last_tick) begin
				tick_cnt <= '0;
				if (sec_cnt == SEC_W'(pcxt_pkg::SPLASH_SECONDS - 1))
					splash_active <= 1'b0;
				else
					sec_cnt <= sec_cnt + 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// One-shot, only reset_wire brings it back
	a_splash_no_rise: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		!splash_active |=> !splash_active)
		else $error("splash_active rose outside reset");

endmodule

/* hw/video_colorizer.sv */
// CGA/Tandy monochrome colorizer

`timescale 1ns/1ps

module video_colorizer (
	input logic CLK_50M,
	input logic reset_wire,
	input pcxt_pkg::core_status_t status,
	input pcxt_pkg::core_pixel_t px_in,
	output pcxt_pkg::vga_pixel_t px_out,
	output logic [pcxt_pkg::ASPECT_BITS-1:0] video_arx,
	output logic [pcxt_pkg::ASPECT_BITS-1:0] video_ary
);

	// Weighted sum of 6-bit channels stays below 2^14
	localparam int LUMA_SUM_BITS = 14;
	localparam int PAD_BITS = pcxt_pkg::VGA_BITS - pcxt_pkg::COLOR_BITS;

	logic [LUMA_SUM_BITS-1:0] luma_sum;
	logic [pcxt_pkg::COLOR_BITS-1:0] luma;
	logic [pcxt_pkg::COLOR_BITS-1:0] luma_half;
	logic [pcxt_pkg::COLOR_BITS-1:0] col_r;
	logic [pcxt_pkg::COLOR_BITS-1:0] col_g;
	logic [pcxt_pkg::COLOR_BITS-1:0] col_b;
	logic mda_mode;

	////////////////////////////////////////////////////////////////////////////
	// Luma
	////////////////////////////////////////////////////////////////////////////

	assign luma_sum = LUMA_SUM_BITS'(pcxt_pkg::LUMA_R_COEF) * LUMA_SUM_BITS'(px_in.r) +
		LUMA_SUM_BITS'(pcxt_pkg::LUMA_G_COEF) * LUMA_SUM_BITS'(px_in.g) +
		LUMA_SUM_BITS'(pcxt_pkg::LUMA_B_COEF) * LUMA_SUM_BITS'(px_in.b);

	// Fraction dropped so at most 62
	assign luma = luma_sum[LUMA_SUM_BITS-1:8];
	// Amber green channel
	assign luma_half = luma >> 1;

	// MDA has its own palette upstream
	assign mda_mode = (status.video_out == pcxt_pkg::VOUT_MDA);

	////////////////////////////////////////////////////////////////////////////
	// Mode select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		col_r = px_in.r;
		col_g = px_in.g;
		col_b = px_in.b;
		if (!mda_mode) begin
			case (status.mono_mode)
				pcxt_pkg::MONO_GREEN: begin
					col_r = '0;
					col_g = luma;
					col_b = '0;
				end
				pcxt_pkg::MONO_AMBER: begin
					col_r = luma;
					col_g = luma_half;
					col_b = '0;
				end
				pcxt_pkg::MONO_BW: begin
					col_r = luma;
					col_g = luma;
					col_b = luma;
				end
				// Colour passes untouched
				default: begin
					col_r = px_in.r;
					col_g = px_in.g;
					col_b = px_in.b;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	// Syncs ride along with the colour
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			px_out <= '0;
		end else begin
			px_out.r <= {col_r, {PAD_BITS{1'b0}}};
			px_out.g <= {col_g, {PAD_BITS{1'b0}}};
			px_out.b <= {col_b, {PAD_BITS{1'b0}}};
			px_out.hsync <= px_in.hsync;
			px_out.vsync <= px_in.vsync;
			px_out.de <= px_in.de;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// HDMI aspect ratio
	////////////////////////////////////////////////////////////////////////////

	// Zero selects original 4:3 and other values pick ARC slots
	always_comb begin
		if (status.aspect == 2'd0) begin
			video_arx = pcxt_pkg::ASPECT_BITS'(pcxt_pkg::ASPECT_ARX_DEFAULT);
			video_ary = pcxt_pkg::ASPECT_BITS'(pcxt_pkg::ASPECT_ARY_DEFAULT);
		end else begin
			video_arx = pcxt_pkg::ASPECT_BITS'(status.aspect - 2'd1);
			video_ary = '0;
		end
	end

endmodule

/* hw/sound_mixer.sv */
// Signed sound mixer

`timescale 1ns/1ps

module sound_mixer (
	input logic CLK_50M,
	input logic reset_wire,
	input pcxt_pkg::sound_in_t sound,
	output logic signed [pcxt_pkg::AUDIO_BITS-1:0] audio_out
);

	localparam int MIX_W = pcxt_pkg::AUDIO_MIX_BITS;

	logic [MIX_W-1:0] opl_term;
	logic [MIX_W-1:0] spk_term;
	logic [MIX_W-1:0] tandy_term;
	logic [MIX_W-1:0] mix;

	// OPL2 sign-extended to 17 bits, x4
	assign opl_term = {sound.opl2[15], sound.opl2} << 2;

	// Speaker toggles bit 15
	assign spk_term = {1'b0, sound.speaker, 15'd0};

	// Tandy 8-bit sample, x64
	assign tandy_term = {3'b000, sound.tandy, 6'd0};

	// Wraps modulo 2^17
	assign mix = opl_term + spk_term + tandy_term;

	// Drop the LSB, keep 16 bits
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			audio_out <= '0;
		else
			audio_out <= $signed(mix[MIX_W-1:1]);
	end

endmodule

/* hw/activity_led.sv */
// Disk activity LED stretcher

`timescale 1ns/1ps

module activity_led #(
	parameter int LED_HOLD = pcxt_pkg::LED_HOLD_DEFAULT
) (
	input logic CLK_50M,
	input logic reset_wire,
	input logic activity,
	output logic led_user
);

	localparam int CNT_W = $clog2(LED_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;

	// Reload on every pulse and otherwise run down to zero
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			hold_cnt <= '0;
		else if (activity)
			hold_cnt <= CNT_W'(LED_HOLD);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	// Lit while the hold runs
	assign led_user = (hold_cnt != '0);

endmodule

/* hw/pcxt_glue_top.sv */
// PC/XT system glue top level

`timescale 1ns/1ps

module pcxt_glue_top #(
	parameter int SYS_RESET_HOLD = pcxt_pkg::SYS_RESET_HOLD_DEFAULT,
	parameter int SPLASH_TICK = pcxt_pkg::SPLASH_TICK_DEFAULT,
	parameter int LED_HOLD = pcxt_pkg::LED_HOLD_DEFAULT
) (
	input logic CLK_50M,
	input logic reset_wire,
	input pcxt_pkg::core_status_t status,
	input logic user_button,
	input pcxt_pkg::download_t download,
	input pcxt_pkg::core_pixel_t px_in,
	input pcxt_pkg::sound_in_t sound,
	input logic disk_activity,
	output logic sys_reset,
	output logic cpu_reset,
	output logic splash_active,
	output pcxt_pkg::vga_pixel_t px_out,
	output logic [pcxt_pkg::ASPECT_BITS-1:0] video_arx,
	output logic [pcxt_pkg::ASPECT_BITS-1:0] video_ary,
	output logic signed [pcxt_pkg::AUDIO_BITS-1:0] audio_out,
	output logic led_user
);

	////////////////////////////////////////////////////////////////////////////
	// Reset path
	////////////////////////////////////////////////////////////////////////////

	// Splash sees only reset_wire, so no loop through sys_reset
	splash_timer #(
		.SPLASH_TICK(SPLASH_TICK)
	) i_splash (
		.CLK_50M(CLK_50M),
		.reset_wire(reset_wire),
		.splash_skip(status.splash_skip),
		.splash_active(splash_active)
	);

	reset_sequencer #(
		.SYS_RESET_HOLD(SYS_RESET_HOLD)
	) i_reset_seq (
		.CLK_50M(CLK_50M),
		.reset_wire(reset_wire),
		.status(status),
		.user_button(user_button),
		.download(download),
		.splash_active(splash_active),
		.sys_reset(sys_reset),
		.cpu_reset(cpu_reset)
	);

	////////////////////////////////////////////////////////////////////////////
	// Video, audio and LED
	////////////////////////////////////////////////////////////////////////////

	video_colorizer i_video (
		.CLK_50M(CLK_50M),
		.reset_wire(reset_wire),
		.status(status),
		.px_in(px_in),
		.px_out(px_out),
		.video_arx(video_arx),
		.video_ary(video_ary)
	);

	sound_mixer i_sound (
		.CLK_50M(CLK_50M),
		.reset_wire(reset_wire),
		.sound(sound),
		.audio_out(audio_out)
	);

	// Floppy and disk access indicator
	activity_led #(
		.LED_HOLD(LED_HOLD)
	) i_led (
		.CLK_50M(CLK_50M),
		.reset_wire(reset_wire),
		.activity(disk_activity),
		.led_user(led_user)
	);

endmodule

/* test/tb_pcxt_glue.sv */
// PC/XT glue testbench

`timescale 1ns/1ps

module tb_pcxt_glue;

	// Whole run is well under half of this
	localparam int CYCLE_LIMIT = 3000;

	logic CLK_50M;
	logic reset_wire;
	pcxt_pkg::core_status_t status;
	logic user_button;
	pcxt_pkg::download_t download;
	pcxt_pkg::core_pixel_t px_in;
	pcxt_pkg::sound_in_t sound;
	logic disk_activity;
	logic sys_reset;
	logic cpu_reset;
	logic splash_active;
	pcxt_pkg::vga_pixel_t px_out;
	logic [pcxt_pkg::ASPECT_BITS-1:0] video_arx;
	logic [pcxt_pkg::ASPECT_BITS-1:0] video_ary;
	logic signed [pcxt_pkg::AUDIO_BITS-1:0] audio_out;
	logic led_user;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int cycle_count = 0;
	logic [31:0] lfsr_state = 32'd73001;

	// Short holds so the whole sequence fits in a few hundred cycles
	pcxt_glue_top #(
		.SYS_RESET_HOLD(16),
		.SPLASH_TICK(20),
		.LED_HOLD(30)
	) i_dut (
		.CLK_50M(CLK_50M),
		.reset_wire(reset_wire),
		.status(status),
		.user_button(user_button),
		.download(download),
		.px_in(px_in),
		.sound(sound),
		.disk_activity(disk_activity),
		.sys_reset(sys_reset),
		.cpu_reset(cpu_reset),
		.splash_active(splash_active),
		.px_out(px_out),
		.video_arx(video_arx),
		.video_ary(video_ary),
		.audio_out(audio_out),
		.led_user(led_user)
	);

	// 50 MHz
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	// Hard stop on a hung test
	always @(posedge CLK_50M) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped at %0t after %0d cycles, a test never finished",
				$time, cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random source and reference rules
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Mode 4 stands for MDA, colour passes through
	function automatic pcxt_pkg::vga_pixel_t expected_pixel(
		input pcxt_pkg::core_pixel_t p, input int mode);
		pcxt_pkg::vga_pixel_t e;
		int y;
		int cr;
		int cg;
		int cb;
		y = (pcxt_pkg::LUMA_R_COEF * int'(p.r) + pcxt_pkg::LUMA_G_COEF * int'(p.g) +
			pcxt_pkg::LUMA_B_COEF * int'(p.b)) / 256;
		cr = int'(p.r);
		cg = int'(p.g);
		cb = int'(p.b);
		case (mode)
			1: begin
				cr = 0;
				cg = y;
				cb = 0;
			end
			2: begin
				cr = y;
				cg = y / 2;
				cb = 0;
			end
			3: begin
				cr = y;
				cg = y;
				cb = y;
			end
			default: ;
		endcase
		// Two zero LSBs widen 6 to 8 bits
		e.r = 8'(cr * 4);
		e.g = 8'(cg * 4);
		e.b = 8'(cb * 4);
		e.hsync = p.hsync;
		e.vsync = p.vsync;
		e.de = p.de;
		return e;
	endfunction

	// Wrapped 17-bit mix, top 16 bits kept
	function automatic logic [15:0] expected_audio(input pcxt_pkg::sound_in_t s);
		int m;
		logic [16:0] w;
		m = int'($signed(s.opl2)) * 4 + int'(s.speaker) * 32768 + int'(s.tandy) * 64;
		w = 17'(m);
		return w[16:1];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (expected == actual) else begin
			$display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_range(input string name, input int lo, input int hi,
		input int actual);
		checks++;
		assert (actual >= lo && actual <= hi) else begin
			$display("FAIL t=%0t %s expected %0d..%0d got %0d", $time, name, lo, hi, actual);
			errors++;
		end
	endtask

	function automatic logic watched_level(input int which);
		case (which)
			0: return splash_active;
			1: return sys_reset;
			2: return cpu_reset;
			default: return led_user;
		endcase
	endfunction

	function automatic string watched_name(input int which);
		case (which)
			0: return "splash_active";
			1: return "sys_reset";
			2: return "cpu_reset";
			default: return "led_user";
		endcase
	endfunction

	// Negedges until the level drops, bounded
	task automatic count_until_low(input int which, input int limit, output int cycles);
		cycles = 0;
		while (watched_level(which) && cycles < limit) begin
			@(negedge CLK_50M);
			cycles++;
		end
		checks++;
		assert (!watched_level(which)) else begin
			$display("At %0t %s was still high after %0d cycles", $time,
				watched_name(which), limit);
			errors++;
		end
	endtask

	task automatic apply_reset();
		reset_wire = 1'b1;
		repeat (4) @(negedge CLK_50M);
		reset_wire = 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errors_before);
	endtask

	// 0 menu reset, 1 user button, 2 BIOS download
	task automatic drive_source(input int source, input logic level);
		case (source)
			0: status.menu_reset = level;
			1: user_button = level;
			default: begin
				download.active = level;
				download.index = 8'(pcxt_pkg::BOOT_ROM_INDEX);
			end
		endcase
	endtask

	task automatic retrigger(input int source);
		int cycles;
		drive_source(source, 1'b1);
		@(negedge CLK_50M);
		check_eq("sys_reset", 32'd1, 32'(sys_reset));
		check_eq("cpu_reset", 32'd1, 32'(cpu_reset));
		repeat (2) @(negedge CLK_50M);
		drive_source(source, 1'b0);
		count_until_low(1, 40, cycles);
		check_range("sys_reset hold", 14, 18, cycles);
		count_until_low(2, 60, cycles);
		check_eq("cpu_reset hold", 32'd42, 32'(cycles));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_splash_timeout();
		int e0;
		int cycles;
		e0 = errors;
		// Starts right at reset release
		count_until_low(0, 120, cycles);
		check_range("splash_active timeout", 98, 102, cycles);
		count_until_low(1, 40, cycles);
		check_range("sys_reset hold", 14, 18, cycles);
		count_until_low(2, 60, cycles);
		check_eq("cpu_reset hold", 32'd42, 32'(cycles));
		report_test("splash timeout", e0);
	endtask

	task automatic test_skip_retrigger();
		int e0;
		int cycles;
		e0 = errors;
		apply_reset();
		status.splash_skip = 1'b1;
		count_until_low(0, 10, cycles);
		check_range("splash_active skip", 1, 2, cycles);
		count_until_low(1, 40, cycles);
		count_until_low(2, 60, cycles);
		for (int s = 0; s < 3; s++)
			retrigger(s);
		// Other download slots leave the core running
		download.active = 1'b1;
		download.index = 8'd1;
		repeat (5) begin
			@(negedge CLK_50M);
			check_eq("sys_reset", 32'd0, 32'(sys_reset));
			check_eq("cpu_reset", 32'd0, 32'(cpu_reset));
		end
		download = '0;
		report_test("skip and retrigger", e0);
	endtask

	task automatic test_video_modes();
		int e0;
		logic [31:0] r;
		pcxt_pkg::vga_pixel_t exp_px;
		e0 = errors;
		for (int m = 0; m < 5; m++) begin
			if (m < 4) begin
				status.video_out = pcxt_pkg::VOUT_CGA;
				status.mono_mode = pcxt_pkg::mono_mode_e'(m[1:0]);
			end else begin
				status.video_out = pcxt_pkg::VOUT_MDA;
				status.mono_mode = pcxt_pkg::MONO_GREEN;
			end
			for (int i = 0; i < 40; i++) begin
				r = take_bits(6);
				px_in.r = r[5:0];
				r = take_bits(6);
				px_in.g = r[5:0];
				r = take_bits(6);
				px_in.b = r[5:0];
				r = take_bits(3);
				{px_in.hsync, px_in.vsync, px_in.de} = r[2:0];
				exp_px = expected_pixel(px_in, m);
				@(negedge CLK_50M);
				check_eq("px_out", 32'(exp_px), 32'(px_out));
			end
		end
		status.video_out = pcxt_pkg::VOUT_CGA;
		status.mono_mode = pcxt_pkg::MONO_COLOR;
		px_in = '0;
		report_test("video modes", e0);
	endtask

	task automatic test_aspect();
		int e0;
		e0 = errors;
		for (int a = 0; a < 4; a++) begin
			status.aspect = a[1:0];
			@(negedge CLK_50M);
			check_eq("video_arx", (a == 0) ? 32'd4 : 32'(a - 1), 32'(video_arx));
			check_eq("video_ary", (a == 0) ? 32'd3 : 32'd0, 32'(video_ary));
		end
		status.aspect = 2'd0;
		report_test("aspect ratio", e0);
	endtask

	task automatic test_sound_mix();
		int e0;
		logic [31:0] r;
		logic [15:0] exp_audio;
		e0 = errors;
		for (int i = 0; i < 40; i++) begin
			// Corners of the range first, then random samples
			case (i)
				0: sound = {16'h7FFF, 1'b1, 8'hFF};
				1: sound = {16'h8000, 1'b0, 8'h00};
				2: sound = {16'h8000, 1'b1, 8'hFF};
				3: sound = {16'hFFFF, 1'b1, 8'h80};
				default: begin
					r = take_bits(16);
					sound.opl2 = r[15:0];
					r = take_bits(1);
					sound.speaker = r[0];
					r = take_bits(8);
					sound.tandy = r[7:0];
				end
			endcase
			exp_audio = expected_audio(sound);
			@(negedge CLK_50M);
			check_eq("audio_out", 32'(exp_audio), 32'($unsigned(audio_out)));
		end
		sound = '0;
		report_test("sound mix", e0);
	endtask

	task automatic test_activity_led();
		int e0;
		int cycles;
		e0 = errors;
		// Single pulse
		disk_activity = 1'b1;
		@(negedge CLK_50M);
		disk_activity = 1'b0;
		check_eq("led_user", 32'd1, 32'(led_user));
		count_until_low(3, 40, cycles);
		check_range("led_user hold", 29, 31, cycles);
		// Pulse train keeps it lit
		repeat (6) begin
			disk_activity = 1'b1;
			@(negedge CLK_50M);
			disk_activity = 1'b0;
			check_eq("led_user", 32'd1, 32'(led_user));
			repeat (9) begin
				@(negedge CLK_50M);
				check_eq("led_user", 32'd1, 32'(led_user));
			end
		end
		count_until_low(3, 40, cycles);
		check_range("led_user tail", 20, 22, cycles);
		report_test("activity led", e0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset_wire = 1'b1;
		status = '0;
		user_button = 1'b0;
		download = '0;
		px_in = '0;
		sound = '0;
		disk_activity = 1'b0;
		apply_reset();
		test_splash_timeout();
		test_skip_retrigger();
		test_video_modes();
		test_aspect();
		test_sound_mix();
		test_activity_led();
		$display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* src.f */
hw/pcxt_pkg.sv
hw/reset_sequencer.sv
hw/splash_timer.sv
hw/video_colorizer.sv
hw/sound_mixer.sv
hw/activity_led.sv
hw/pcxt_glue_top.sv
test/tb_pcxt_glue.sv

/* Makefile */
TOP = tb_pcxt_glue
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f hw/*.sv test/*.sv
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
